//--- flist.f
logic/fetch_pkg.sv
logic/line_aligner.sv
logic/l0_line_buffer.sv
logic/fetch_cfg.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
tb/fetch_props.sv
tb/fetch_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := fetch_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_TEXT  := ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;
    import fetch_pkg::*;

    localparam int N_RANDOM = 300;
    localparam int N_TESTS  = N_RANDOM + 20;   // directed accesses plus the random mix
    localparam int GRP_BITS = SUPER_SCALAR_WIDTH * (INSTRUCTION_WIDTH + 1);

    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic [7:0]          width;   // issue width in force at acceptance
    } expect_t;

    logic                          clk_in, rst_N_in, flush_in;
    logic                          pc_valid, fetch_ready, l1i_req, l1i_valid;
    logic                          cfg_we, fetch_valid;
    logic [PC_WIDTH-1:0]           pred_pc, l1i_addr, fetch_pc;
    logic [7:0]                    l1i_line [LINE_BYTES-1:0];
    logic [7:0]                    cfg_wdata;
    cfg_addr_e                     cfg_addr;
    logic [INSTRUCTION_WIDTH-1:0]  fetched_instrs [SUPER_SCALAR_WIDTH-1:0];
    logic [SUPER_SCALAR_WIDTH-1:0] slot_valid;

    int                  seed = 83038;
    expect_t             exp_q [$];
    expect_t             ent;
    logic [GRP_BITS-1:0] grp;
    logic [7:0]          m_width;                 // issue width register model
    logic                m_valid, pend, stale, req_due;
    logic [PC_WIDTH-1:0] m_pc, pend_pc;           // line held in the L0 model, pc in flight

    fetch_top DUT (.*);

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // line bytes come from the line address so the checker can rebuild them
    function automatic logic [7:0] line_byte(input logic [PC_WIDTH-1:0] addr, input int b);
        logic [31:0] h;
        h = (addr >> OFFSET_BITS) * 32'h9e3779b1 + 32'(b) * 32'h85eb;
        return h[31:24] ^ h[7:0];
    endfunction

    // expected group as {mask, slot n-1 .. slot 0}
    function automatic logic [GRP_BITS-1:0] ref_group(input logic [PC_WIDTH-1:0] pc,
                                                      input int width);
        logic [GRP_BITS-1:0] g;
        int pos;
        g = '0;
        for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
            pos = int'(pc[OFFSET_BITS-1:0]) + 4 * i;
            if (i < width && pos + 3 < LINE_BYTES) begin
                g[SUPER_SCALAR_WIDTH * INSTRUCTION_WIDTH + i] = 1'b1;
                for (int b = 0; b < 4; b++)
                    g[i * INSTRUCTION_WIDTH + 8 * b +: 8] = line_byte(pc, pos + b);
            end
        end
        return g;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    // L1I answers each request after 1 to 6 cycles
    initial begin
        int lat;
        logic [PC_WIDTH-1:0] addr;
        l1i_valid = 1'b0;
        for (int b = 0; b < LINE_BYTES; b++)
            l1i_line[b] = 8'h00;
        forever begin
            @(posedge clk_in);
            if (l1i_req && !rst_N_in) begin
                addr = l1i_addr;
                lat  = 1 + ($random(seed) & 'h7fff) % 6;
                repeat (lat - 1) @(posedge clk_in);
                l1i_valid <= 1'b1;
                for (int b = 0; b < LINE_BYTES; b++)
                    l1i_line[b] <= line_byte(addr, b);
                @(posedge clk_in);
                l1i_valid <= 1'b0;
            end
        end
    end

    // scoreboard sees the values from before each edge
    always @(posedge clk_in) begin
        if (rst_N_in) begin
            exp_q.delete();
            m_width = 8'(SUPER_SCALAR_WIDTH);
            m_valid = 1'b0;
            pend    = 1'b0;
            stale   = 1'b0;
            req_due = 1'b0;
        end else begin
            if (fetch_valid) begin
                if (exp_q.size() == 0) begin
                    abort_run("a group reached decode but no accepted pc was waiting for it");
                end else begin
                    ent = exp_q.pop_front();
                    grp = ref_group(ent.pc, int'(ent.width));
                    check_value("slot_valid", 32'(slot_valid),
                                32'(grp[GRP_BITS-1 -: SUPER_SCALAR_WIDTH]));
                    for (int i = 0; i < SUPER_SCALAR_WIDTH; i++)
                        check_value($sformatf("slot %0d instruction", i), fetched_instrs[i],
                                    grp[i * INSTRUCTION_WIDTH +: INSTRUCTION_WIDTH]);
                    check_value("fetch_pc", fetch_pc, ent.pc);
                end
            end
            check_value("l1i_req", 32'(l1i_req), 32'(req_due));
            if (l1i_req)
                check_value("l1i_addr", l1i_addr, pend_pc & ~PC_WIDTH'(LINE_BYTES - 1));
            req_due = 1'b0;
            if (pend) begin
                stale = stale || flush_in;
                if (l1i_valid) begin
                    if (!stale) begin   // only a live response lands in the L0
                        m_valid = 1'b1;
                        m_pc    = pend_pc;
                    end
                    pend  = 1'b0;
                    stale = 1'b0;
                end
            end
            if (flush_in)
                exp_q.delete();
            if (pc_valid && fetch_ready && !flush_in) begin
                exp_q.push_back('{pc: pred_pc, width: m_width});
                if (!(m_valid &&
                      m_pc[PC_WIDTH-1:OFFSET_BITS] == pred_pc[PC_WIDTH-1:OFFSET_BITS])) begin
                    req_due = 1'b1;   // miss
                    pend    = 1'b1;
                    pend_pc = pred_pc;
                end
            end
            if (cfg_we && cfg_addr == CFG_WIDTH)
                m_width = (cfg_wdata == 8'd0) ? 8'd1 :
                          (cfg_wdata > 8'(SUPER_SCALAR_WIDTH)) ? 8'(SUPER_SCALAR_WIDTH) : cfg_wdata;
        end
    end

    // hold the pc until an edge accepts it
    task automatic send_pc(input logic [PC_WIDTH-1:0] pc);
        pc_valid <= 1'b1;
        pred_pc  <= pc;
        @(posedge clk_in);
        while (!(fetch_ready && !flush_in))
            @(posedge clk_in);
    endtask

    task automatic write_cfg(input cfg_addr_e addr, input logic [7:0] data);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk_in);
        cfg_we    <= 1'b0;
    endtask

    task automatic wait_ready();
        pc_valid <= 1'b0;
        @(posedge clk_in);
        while (!fetch_ready)
            @(posedge clk_in);
    endtask

    initial begin
        int r;
        rst_N_in  = 1'b1;
        flush_in  = 1'b0;
        pc_valid  = 1'b0;
        pred_pc   = '0;
        cfg_we    = 1'b0;
        cfg_addr  = CFG_ENABLE;
        cfg_wdata = 8'd0;
        repeat (16) @(posedge clk_in);
        rst_N_in <= 1'b0;
        wait_ready();

        send_pc(32'h0000_1000);   // cold miss
        wait_ready();
        send_pc(32'h0000_1004);
        send_pc(32'h0000_1008);
        send_pc(32'h0000_100c);   // second slot runs off the line
        send_pc(32'h0000_1009);
        send_pc(32'h0000_100d);   // first slot already leaves the line
        wait_ready();

        // width limit where zero clamps to one
        write_cfg(CFG_WIDTH, 8'd1);
        send_pc(32'h0000_1000);
        wait_ready();
        write_cfg(CFG_WIDTH, 8'd0);
        send_pc(32'h0000_1004);
        wait_ready();
        write_cfg(CFG_WIDTH, 8'd2);
        send_pc(32'h0000_1000);
        wait_ready();

        // flush while the miss is in flight so the same line has to miss again
        send_pc(32'h0000_2000);
        pc_valid <= 1'b0;
        flush_in <= 1'b1;
        @(posedge clk_in);
        flush_in <= 1'b0;
        wait_ready();
        send_pc(32'h0000_2004);
        wait_ready();

        write_cfg(CFG_ENABLE, 8'd0);
        pc_valid <= 1'b1;
        pred_pc  <= 32'h0000_3000;
        repeat (8) begin
            @(posedge clk_in);
            check_value("fetch_ready while disabled", 32'(fetch_ready), 32'd0);
        end
        pc_valid <= 1'b0;
        write_cfg(CFG_ENABLE, 8'd1);
        send_pc(32'h0000_3000);
        wait_ready();

        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            send_pc(32'h0000_4000 + 32'(r[5:0]));   // four lines at any byte offset
            if (r[10:8] == 3'd0) begin
                pc_valid <= 1'b0;
                repeat (r[12:11]) @(posedge clk_in);
                flush_in <= 1'b1;
                @(posedge clk_in);
                flush_in <= 1'b0;
            end else if (r[15:13] == 3'd0) begin
                wait_ready();
                write_cfg(CFG_WIDTH, 8'(r[18:16]));
            end
        end
        wait_ready();
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d accepted pcs never got their group", exp_q.size()));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    initial begin
        repeat (N_TESTS * 10 + 200) @(posedge clk_in);
        abort_run("timeout: the tests did not finish in the expected number of cycles");
    end

endmodule

//--- tb/fetch_props.sv
`timescale 1ns/1ns

module fetch_props (
    input logic                    clk_in,
    input logic                    rst_N_in,
    input logic                    flush_in,
    input fetch_pkg::fetch_state_e state,
    input logic                    l1i_req,
    input logic                    l1i_valid,
    input logic                    fetch_valid,
    input logic                    fetch_ready
);
    import fetch_pkg::*;

    logic in_flight;   // request sent and its line not back yet

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            in_flight <= 1'b0;
        end else if (l1i_req) begin
            in_flight <= 1'b1;
        end else if (l1i_valid) begin
            in_flight <= 1'b0;
        end
    end

    // at most one line owed by the L1I at any time
    single_req: assert property (@(posedge clk_in) disable iff (rst_N_in)
        l1i_req |-> !in_flight)
        else $error("l1i_req issued while a request was outstanding");

    flush_kills_group: assert property (@(posedge clk_in) disable iff (rst_N_in)
        flush_in |=> !fetch_valid)
        else $error("fetch_valid high in the cycle after a flush");

    // no new pc while the L1I owes a line
    busy_not_ready: assert property (@(posedge clk_in) disable iff (rst_N_in)
        state != FS_IDLE |-> !fetch_ready)
        else $error("fetch_ready high while a request is outstanding");

endmodule

bind fetch_ctrl fetch_props props (
    .clk_in(clk_in), .rst_N_in(rst_N_in), .flush_in(flush_in), .state(state),
    .l1i_req(l1i_req), .l1i_valid(l1i_valid), .fetch_valid(fetch_valid),
    .fetch_ready(fetch_ready)
);

//--- logic/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                                  clk_in,
    input  logic                                  rst_N_in,
    input  logic                                  flush_in,
    // predictor side
    input  logic                                  pc_valid,
    input  logic [fetch_pkg::PC_WIDTH-1:0]         pred_pc,
    output logic                                  fetch_ready,
    // L1I side
    output logic                                  l1i_req,
    output logic [fetch_pkg::PC_WIDTH-1:0]         l1i_addr,
    input  logic                                  l1i_valid,
    input  logic [7:0]                            l1i_line [fetch_pkg::LINE_BYTES-1:0],
    // config writes
    input  logic                                  cfg_we,
    input  fetch_pkg::cfg_addr_e                  cfg_addr,
    input  logic [7:0]                            cfg_wdata,
    // decode side
    output logic                                  fetch_valid,
    output logic [fetch_pkg::INSTRUCTION_WIDTH-1:0] fetched_instrs [fetch_pkg::SUPER_SCALAR_WIDTH-1:0],
    output logic [fetch_pkg::SUPER_SCALAR_WIDTH-1:0] slot_valid,
    output logic [fetch_pkg::PC_WIDTH-1:0]         fetch_pc
);
    import fetch_pkg::*;

    logic                          fill_en;
    logic [PC_WIDTH-1:0]           fill_addr;
    logic                          l0_hit;
    logic [7:0]                    l0_line [LINE_BYTES-1:0];
    logic [OFFSET_BITS-1:0]        req_offset;
    logic [INSTRUCTION_WIDTH-1:0]  l0_instrs [SUPER_SCALAR_WIDTH-1:0];
    logic [INSTRUCTION_WIDTH-1:0]  l1i_instrs [SUPER_SCALAR_WIDTH-1:0];
    logic [SUPER_SCALAR_WIDTH-1:0] l0_in_line;
    logic [SUPER_SCALAR_WIDTH-1:0] l1i_in_line;
    logic                          fetch_en;
    logic [SLOT_BITS-1:0]          issue_width;

    l0_line_buffer l0_buf (
        .clk_in(clk_in), .rst_N_in(rst_N_in), .lookup_pc(pred_pc),
        .fill_en(fill_en), .fill_addr(fill_addr), .fill_line(l1i_line),
        .l0_hit(l0_hit), .l0_line(l0_line)
    );

    // hit path aligns on the incoming pc
    line_aligner l0_align (
        .offset(pred_pc[OFFSET_BITS-1:0]), .line(l0_line),
        .instrs(l0_instrs), .in_line(l0_in_line)
    );

    // miss path aligns on the pc stored with the request
    line_aligner l1i_align (
        .offset(req_offset), .line(l1i_line),
        .instrs(l1i_instrs), .in_line(l1i_in_line)
    );

    fetch_cfg cfg (
        .clk_in(clk_in), .rst_N_in(rst_N_in), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .fetch_en(fetch_en), .issue_width(issue_width)
    );

    fetch_ctrl ctrl (
        .clk_in(clk_in), .rst_N_in(rst_N_in), .flush_in(flush_in),
        .pc_valid(pc_valid), .pred_pc(pred_pc),
        .fetch_en(fetch_en), .issue_width(issue_width),
        .l0_hit(l0_hit), .l0_instrs(l0_instrs), .l0_in_line(l0_in_line),
        .l1i_valid(l1i_valid), .l1i_instrs(l1i_instrs), .l1i_in_line(l1i_in_line),
        .fill_en(fill_en), .fill_addr(fill_addr), .req_offset(req_offset),
        .l1i_req(l1i_req), .l1i_addr(l1i_addr), .fetch_ready(fetch_ready),
        .fetch_valid(fetch_valid), .fetched_instrs(fetched_instrs),
        .slot_valid(slot_valid), .fetch_pc(fetch_pc)
    );

endmodule

//--- logic/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic clk_in,
    input  logic rst_N_in,
    input  logic flush_in,
    input  logic pc_valid,
    input  logic [fetch_pkg::PC_WIDTH-1:0] pred_pc,
    input  logic fetch_en,
    input  logic [fetch_pkg::SLOT_BITS-1:0] issue_width,
    input  logic l0_hit,
    input  logic [fetch_pkg::INSTRUCTION_WIDTH-1:0] l0_instrs [fetch_pkg::SUPER_SCALAR_WIDTH-1:0],
    input  logic [fetch_pkg::SUPER_SCALAR_WIDTH-1:0] l0_in_line,
    input  logic l1i_valid,
    input  logic [fetch_pkg::INSTRUCTION_WIDTH-1:0] l1i_instrs [fetch_pkg::SUPER_SCALAR_WIDTH-1:0],
    input  logic [fetch_pkg::SUPER_SCALAR_WIDTH-1:0] l1i_in_line,
    output logic fill_en,
    output logic [fetch_pkg::PC_WIDTH-1:0] fill_addr,
    output logic [fetch_pkg::OFFSET_BITS-1:0] req_offset,
    output logic l1i_req,
    output logic [fetch_pkg::PC_WIDTH-1:0] l1i_addr,
    output logic fetch_ready,
    output logic fetch_valid,
    output logic [fetch_pkg::INSTRUCTION_WIDTH-1:0] fetched_instrs [fetch_pkg::SUPER_SCALAR_WIDTH-1:0],
    output logic [fetch_pkg::SUPER_SCALAR_WIDTH-1:0] slot_valid,
    output logic [fetch_pkg::PC_WIDTH-1:0] fetch_pc
);
    import fetch_pkg::*;

    fetch_state_e state, state_next;
    logic ready_q;                       // idle and out of reset
    logic [PC_WIDTH-1:0] req_pc;         // pc of the outstanding miss
    logic [SLOT_BITS-1:0] req_width;     // issue width seen when the miss was accepted
    logic accept, hit_go, miss_go, resp_ok, deliver;
    logic [SLOT_BITS-1:0] grp_width;
    logic [SUPER_SCALAR_WIDTH-1:0] grp_valid;
    logic [INSTRUCTION_WIDTH-1:0] grp_instrs [SUPER_SCALAR_WIDTH-1:0];

    assign fetch_ready = ready_q && fetch_en;
    assign accept  = pc_valid && fetch_ready && !flush_in;
    assign hit_go  = accept && l0_hit;
    assign miss_go = accept && !l0_hit;
    assign resp_ok = (state == FS_WAIT_L1I) && l1i_valid && !flush_in;  // live response
    assign deliver = hit_go || resp_ok;

    assign fill_en    = resp_ok;     // a flushed response never reaches the L0
    assign fill_addr  = req_pc;
    assign req_offset = req_pc[OFFSET_BITS-1:0];
    assign l1i_addr   = {req_pc[PC_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    always_comb begin
        state_next = state;
        case (state)
            FS_IDLE: if (miss_go) state_next = FS_WAIT_L1I;
            FS_WAIT_L1I: begin
                if (l1i_valid) state_next = FS_IDLE;          // flushed or not, request is done
                else if (flush_in) state_next = FS_DISCARD;
            end
            FS_DISCARD: if (l1i_valid) state_next = FS_IDLE;  // stale line dropped here
            default: state_next = FS_IDLE;
        endcase
    end

    // group build, the returning line wins over the L0
    assign grp_width = resp_ok ? req_width : issue_width;

    always_comb begin
        for (int i = 0; i < SUPER_SCALAR_WIDTH; i++) begin
            grp_valid[i] = (SLOT_BITS'(i) < grp_width) &&
                           (resp_ok ? l1i_in_line[i] : l0_in_line[i]);
            grp_instrs[i] = '0;  // slots cut by the width read as zero too
            if (grp_valid[i]) begin
                grp_instrs[i] = resp_ok ? l1i_instrs[i] : l0_instrs[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            state       <= FS_IDLE;
            ready_q     <= 1'b0;
            l1i_req     <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            state       <= state_next;
            ready_q     <= (state_next == FS_IDLE);
            l1i_req     <= miss_go;    // one cycle pulse
            fetch_valid <= deliver;    // flush keeps this low
        end
    end

    always_ff @(posedge clk_in) begin
        if (miss_go) begin
            req_pc    <= pred_pc;
            req_width <= issue_width;
        end
        if (deliver) begin
            fetched_instrs <= grp_instrs;
            slot_valid     <= grp_valid;
            fetch_pc       <= resp_ok ? req_pc : pred_pc;
        end
    end

endmodule

//--- logic/fetch_cfg.sv
`timescale 1ns/1ns

module fetch_cfg (
    input  logic                           clk_in,
    input  logic                           rst_N_in,
    input  logic                           cfg_we,
    input  fetch_pkg::cfg_addr_e           cfg_addr,
    input  logic [7:0]                     cfg_wdata,
    output logic                           fetch_en,
    output logic [fetch_pkg::SLOT_BITS-1:0] issue_width
);
    import fetch_pkg::*;

    logic [SLOT_BITS-1:0] width_clamped;

    // keep the width in 1..SUPER_SCALAR_WIDTH whatever gets written
    always_comb begin
        if (cfg_wdata == 8'd0) begin
            width_clamped = SLOT_BITS'(1);
        end else if (cfg_wdata > 8'(SUPER_SCALAR_WIDTH)) begin
            width_clamped = SLOT_BITS'(SUPER_SCALAR_WIDTH);
        end else begin
            width_clamped = cfg_wdata[SLOT_BITS-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            fetch_en    <= 1'b1;                        // fetch runs out of reset
            issue_width <= SLOT_BITS'(SUPER_SCALAR_WIDTH);
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_ENABLE: fetch_en    <= cfg_wdata[0];
                CFG_WIDTH:  issue_width <= width_clamped;
            endcase
        end
    end

endmodule

//--- logic/l0_line_buffer.sv
`timescale 1ns/1ns

module l0_line_buffer (
    input  logic                          clk_in,
    input  logic                          rst_N_in,
    input  logic [fetch_pkg::PC_WIDTH-1:0] lookup_pc,   // predicted pc being looked up
    input  logic                          fill_en,
    input  logic [fetch_pkg::PC_WIDTH-1:0] fill_addr,   // any address inside the filled line
    input  logic [7:0]                    fill_line [fetch_pkg::LINE_BYTES-1:0],
    output logic                          l0_hit,
    output logic [7:0]                    l0_line [fetch_pkg::LINE_BYTES-1:0]
);
    import fetch_pkg::*;

    logic [PC_WIDTH-OFFSET_BITS-1:0] tag;   // line address of the held line
    logic                            valid;

    // valid bit is the only state that needs clearing
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            valid <= 1'b0;
        end else if (fill_en) begin
            valid <= 1'b1;
        end
    end

    // tag and data are replaced as a whole on every fill
    always_ff @(posedge clk_in) begin
        if (fill_en) begin
            tag     <= fill_addr[PC_WIDTH-1:OFFSET_BITS];
            l0_line <= fill_line;
        end
    end

    // compare on the line address only, the offset picks slots later
    assign l0_hit = valid && (tag == lookup_pc[PC_WIDTH-1:OFFSET_BITS]);

endmodule

//--- logic/line_aligner.sv
`timescale 1ns/1ns

module line_aligner (
    input  logic [fetch_pkg::OFFSET_BITS-1:0]       offset,
    input  logic [7:0]                              line [fetch_pkg::LINE_BYTES-1:0],
    output logic [fetch_pkg::INSTRUCTION_WIDTH-1:0] instrs [fetch_pkg::SUPER_SCALAR_WIDTH-1:0],
    output logic [fetch_pkg::SUPER_SCALAR_WIDTH-1:0] in_line
);
    import fetch_pkg::*;

    for (genvar i = 0; i < SUPER_SCALAR_WIDTH; i++) begin : g_slot
        logic [POS_BITS-1:0] first_byte;
        logic [POS_BITS-1:0] last_byte;

        assign first_byte = {1'b0, offset} + POS_BITS'(i * INSTR_BYTES);
        assign last_byte  = first_byte + POS_BITS'(INSTR_BYTES - 1);

        // the slot counts only if its last byte still sits in this line
        assign in_line[i] = last_byte < POS_BITS'(LINE_BYTES);

        always_comb begin
            instrs[i] = '0;  // slots past the end read as zero, no wrap into the line start
            if (in_line[i]) begin
                for (int b = 0; b < INSTR_BYTES; b++) begin
                    // little endian, lowest address lands in the low byte
                    instrs[i][8*b +: 8] = line[first_byte[OFFSET_BITS-1:0] + OFFSET_BITS'(b)];
                end
            end
        end
    end

endmodule

//--- logic/fetch_pkg.sv
package fetch_pkg;

    // instruction and group sizes
    localparam int INSTRUCTION_WIDTH  = 32;
    localparam int SUPER_SCALAR_WIDTH = 2;           // max instructions handed to decode per cycle
    localparam int INSTR_BYTES        = INSTRUCTION_WIDTH / 8;

    // cache line geometry
    localparam int LINE_BYTES  = 16;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES); // byte offset inside a line
    localparam int POS_BITS    = OFFSET_BITS + 1;    // byte position that may run past the line

    localparam int PC_WIDTH = 32;

    // issue width field, must be able to hold SUPER_SCALAR_WIDTH itself
    localparam int SLOT_BITS = $clog2(SUPER_SCALAR_WIDTH + 1);

    // fetch controller states
    typedef enum logic [1:0] {
        FS_IDLE     = 2'd0,  // ready for a pc
        FS_WAIT_L1I = 2'd1,  // miss request outstanding
        FS_DISCARD  = 2'd2   // flushed request outstanding, drop its response
    } fetch_state_e;

    // config register map
    typedef enum logic [0:0] {
        CFG_ENABLE = 1'b0,   // bit 0 is the fetch enable
        CFG_WIDTH  = 1'b1    // issue width limit
    } cfg_addr_e;

endpackage
